//--- verilog/srlPkg.sv
//////////////////////////////
// srlPkg
// widths, operation codes and payload structs shared by the shift/rotate/logic lane.
//////////////////////////////

package srlPkg;

	localparam int dataWidth  = 32;
	localparam int shamtWidth = 5; // low bits of data2.
	localparam int issueWidth = 4;

	typedef logic [dataWidth-1:0]  data_t;
	typedef logic [issueWidth-1:0] issueNo_t;

	// operation classes.
	localparam logic [1:0] classShift  = 2'd0;
	localparam logic [1:0] classRotate = 2'd1;
	localparam logic [1:0] classLogic  = 2'd2;
	localparam logic [1:0] classNone   = 2'd3; // reserved class returns zero.

	// shift functions. code 3 acts as sll.
	localparam logic [1:0] fnSll = 2'd0;
	localparam logic [1:0] fnSrl = 2'd1;
	localparam logic [1:0] fnSra = 2'd2;

	// rotate functions. codes 2 and 3 alias rol and ror.
	localparam logic [1:0] fnRol = 2'd0;
	localparam logic [1:0] fnRor = 2'd1;

	// logic functions.
	localparam logic [1:0] fnAnd  = 2'd0;
	localparam logic [1:0] fnOr   = 2'd1;
	localparam logic [1:0] fnXor  = 2'd2;
	localparam logic [1:0] fnAndn = 2'd3; // data1 & ~data2.

	typedef struct packed {
		logic [1:0] opClass;
		logic [1:0] func;
	} srlOp_t;

	// one request, 72 bits.
	typedef struct packed {
		srlOp_t   op;
		data_t    data1;
		data_t    data2;
		issueNo_t issueNo;
	} srlReq_t;

	// one result, 36 bits.
	typedef struct packed {
		data_t    data;
		issueNo_t issueNo;
	} srlResult_t;

endpackage

//--- verilog/shiftRotateUnit.sv
//////////////////////////////
// shiftRotateUnit
// stage-1 register for logical/arithmetic shifts and rotates.
//////////////////////////////
`timescale 1ns/10ps

module shiftRotateUnit (
	input  logic               clock,
	input  logic               reset,
	input  logic               load,
	input  srlPkg::srlReq_t    req,
	input  logic               advance,
	output logic               valid,
	output srlPkg::srlResult_t result
);
	import srlPkg::*;

	logic                   ownClass;
	logic                   loadHere;
	logic [shamtWidth-1:0]  shamt;
	logic [2*dataWidth-1:0] rotLeft;
	logic [2*dataWidth-1:0] rotRight;
	data_t                  shiftData;
	data_t                  rotateData;
	data_t                  nextData;

	assign ownClass = (req.op.opClass == classShift) || (req.op.opClass == classRotate);
	assign loadHere = load && ownClass;
	assign shamt    = req.data2[shamtWidth-1:0];

	always_comb begin
		case (req.op.func)
			fnSrl:   shiftData = req.data1 >> shamt;
			fnSra:   shiftData = $signed(req.data1) >>> shamt; // sign fill.
			default: shiftData = req.data1 << shamt; // sll and code 3.
		endcase
	end

	// rotate through a doubled copy of data1.
	assign rotLeft  = {req.data1, req.data1} << shamt;
	assign rotRight = {req.data1, req.data1} >> shamt;

	always_comb begin
		case (req.op.func)
			fnRol:   rotateData = rotLeft[2*dataWidth-1:dataWidth];
			fnRor:   rotateData = rotRight[dataWidth-1:0];
			2'd2:    rotateData = rotLeft[2*dataWidth-1:dataWidth]; // alias of rol.
			default: rotateData = rotRight[dataWidth-1:0]; // alias of ror.
		endcase
	end

	assign nextData = (req.op.opClass == classRotate) ? rotateData : shiftData;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (loadHere) begin
			valid <= 1'b1; // a new entry may replace one that advances.
		end else if (advance) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (loadHere) begin
			result.data    <= nextData;
			result.issueNo <= req.issueNo;
		end
	end

endmodule

//--- verilog/logicUnit.sv
//////////////////////////////
// logicUnit
// stage-1 register for bitwise operations and the reserved zero class.
//////////////////////////////
`timescale 1ns/10ps

module logicUnit (
	input  logic               clock,
	input  logic               reset,
	input  logic               load,
	input  srlPkg::srlReq_t    req,
	input  logic               advance,
	output logic               valid,
	output srlPkg::srlResult_t result
);
	import srlPkg::*;

	logic  loadHere;
	data_t logicData;

	assign loadHere = load && ((req.op.opClass == classLogic) || (req.op.opClass == classNone));

	always_comb begin
		logicData = '0; // class 3 stays zero.
		if (req.op.opClass == classLogic) begin
			case (req.op.func)
				fnAnd:  logicData = req.data1 & req.data2;
				fnOr:   logicData = req.data1 | req.data2;
				fnXor:  logicData = req.data1 ^ req.data2;
				fnAndn: logicData = req.data1 & ~req.data2;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (loadHere) begin
			valid <= 1'b1;
		end else if (advance) begin
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (loadHere) begin
			result.data    <= logicData;
			result.issueNo <= req.issueNo;
		end
	end

endmodule

//--- verilog/srlResultStage.sv
//////////////////////////////
// srlResultStage
// output register of the lane, with advance and issue-ready generation.
//////////////////////////////
`timescale 1ns/10ps

module srlResultStage (
	input  logic               clock,
	input  logic               reset,
	input  logic               shiftValid,
	input  logic               logicValid,
	input  srlPkg::srlResult_t shiftResult,
	input  srlPkg::srlResult_t logicResult,
	input  logic               outReady,
	output logic               advance,
	output logic               inReady,
	output logic               outValid,
	output srlPkg::srlResult_t outResult
);
	import srlPkg::*;

	logic       stageValid;
	srlResult_t stageResult;

	// at most one unit holds an entry at a time.
	assign stageValid  = shiftValid || logicValid;
	assign stageResult = shiftValid ? shiftResult : logicResult;

	// stage 2 frees up when empty or being consumed.
	assign advance = !outValid || outReady;

	// stage 1 can take a request if it is empty or moves on this cycle.
	assign inReady = !stageValid || advance;

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= stageValid; // clears when nothing waits in stage 1.
		end
	end

	// payload only changes when a new entry moves in.
	always_ff @(posedge clock) begin
		if (advance && stageValid) begin
			outResult <= stageResult;
		end
	end

endmodule

//--- verilog/srlUnit.sv
//////////////////////////////
// srlUnit
// shift, rotate and logic execution lane, two stages with valid/ready on both sides.
//////////////////////////////
`timescale 1ns/10ps

module srlUnit (
	input  logic               clock,
	input  logic               reset,
	input  logic               inValid,
	output logic               inReady,
	input  srlPkg::srlReq_t    inReq,
	output logic               outValid,
	input  logic               outReady,
	output srlPkg::srlResult_t outResult
);
	import srlPkg::*;

	logic       accept;
	logic       advance;
	logic       shiftValid;
	logic       logicValid;
	srlResult_t shiftResult;
	srlResult_t logicResult;

	assign accept = inValid && inReady; // request taken this edge.

	// classes 0 and 1.
	shiftRotateUnit u_shiftRotateUnit (
		.clock   (clock),
		.reset   (reset),
		.load    (accept),
		.req     (inReq),
		.advance (advance),
		.valid   (shiftValid),
		.result  (shiftResult)
	);

	// classes 2 and 3.
	logicUnit u_logicUnit (
		.clock   (clock),
		.reset   (reset),
		.load    (accept),
		.req     (inReq),
		.advance (advance),
		.valid   (logicValid),
		.result  (logicResult)
	);

	srlResultStage u_srlResultStage (
		.clock       (clock),
		.reset       (reset),
		.shiftValid  (shiftValid),
		.logicValid  (logicValid),
		.shiftResult (shiftResult),
		.logicResult (logicResult),
		.outReady    (outReady),
		.advance     (advance),
		.inReady     (inReady),
		.outValid    (outValid),
		.outResult   (outResult)
	);

endmodule

//--- tests/srlUnit_chk.sv
//////////////////////////////
// srlUnit_chk
// handshake assertions bound into the lane top level.
//////////////////////////////
`timescale 1ns/10ps

module srlUnit_chk (
	input logic               clock,
	input logic               reset,
	input logic               outValid,
	input logic               outReady,
	input srlPkg::srlResult_t outResult,
	input logic               shiftValid,
	input logic               logicValid
);
	int failCount = 0; // assertion failures so far.

	// output register comes out of reset empty.
	assert property (@(posedge clock) reset |=> !outValid)
		else begin
			failCount++;
			$error("outValid high in the cycle after reset");
		end

	assert property (@(posedge clock) disable iff (reset)
			outValid && !outReady |=> outValid && $stable(outResult))
		else begin
			failCount++;
			$error("stalled result dropped or changed");
		end

	// one request per cycle, so only one unit holds an entry.
	assert property (@(posedge clock) disable iff (reset) !(shiftValid && logicValid))
		else begin
			failCount++;
			$error("both stage-1 entries valid at once");
		end

endmodule

bind srlUnit srlUnit_chk u_chk (
	.clock      (clock),
	.reset      (reset),
	.outValid   (outValid),
	.outReady   (outReady),
	.outResult  (outResult),
	.shiftValid (shiftValid),
	.logicValid (logicValid)
);

//--- tests/srlUnitTb.sv
//////////////////////////////
// srlUnitTb
// directed and random stimulus for the lane, checked against a reference model.
//////////////////////////////
`timescale 1ns/10ps

module srlUnitTb;
	import srlPkg::*;

	localparam int resetCycles = 8;
	localparam int randomCount = 150;
	localparam int drainLimit  = 5000;
	localparam int stallLimit  = 50;

	logic       clock;
	logic       reset;
	logic       inValid;
	logic       inReady;
	srlReq_t    inReq;
	logic       outValid;
	logic       outReady;
	srlResult_t outResult;

	srlReq_t    reqQ[$]; // requests not yet offered.
	srlResult_t expQ[$]; // expected results, in acceptance order.
	srlResult_t heldResult;
	logic       heldPending;
	logic       taken;
	logic       lastInReady;
	issueNo_t   nextIssue;
	int         readyMode; // 0 random, 1 held low, 2 held high.
	int         acceptCount;
	int         consumeCount;
	int         valueErrors;
	int         flowErrors;
	int         timeouts;
	int         assertErrors;

	srlUnit u_dut (
		.clock     (clock),
		.reset     (reset),
		.inValid   (inValid),
		.inReady   (inReady),
		.inReq     (inReq),
		.outValid  (outValid),
		.outReady  (outReady),
		.outResult (outResult)
	);

	always #5 clock = ~clock;

	function automatic bit chance(input int pct);
		return ($urandom % 100) < pct;
	endfunction

	// expected result straight from the operation rules.
	function automatic srlResult_t modelResult(input srlReq_t r);
		srlResult_t m;
		data_t      ones;
		int         a;
		ones      = '1;
		a         = int'(r.data2[shamtWidth-1:0]);
		m.issueNo = r.issueNo;
		m.data    = '0; // reserved class.
		if (r.op.opClass == classShift) begin
			if (r.op.func == fnSrl || r.op.func == fnSra) begin
				m.data = r.data1 >> a;
				if (r.op.func == fnSra && r.data1[dataWidth-1]) begin
					m.data = m.data | ~(ones >> a); // sign fill.
				end
			end else begin
				m.data = r.data1 << a;
			end
		end else if (r.op.opClass == classRotate) begin
			// a shift by the full width gives zero, so amount 0 returns data1.
			if (r.op.func[0] == 1'b0) begin
				m.data = (r.data1 << a) | (r.data1 >> (dataWidth - a));
			end else begin
				m.data = (r.data1 >> a) | (r.data1 << (dataWidth - a));
			end
		end else if (r.op.opClass == classLogic) begin
			case (r.op.func)
				fnAnd:   m.data = r.data1 & r.data2;
				fnOr:    m.data = r.data1 | r.data2;
				fnXor:   m.data = r.data1 ^ r.data2;
				default: m.data = r.data1 & ~r.data2;
			endcase
		end
		return m;
	endfunction

	task automatic queueReq(input logic [1:0] opClass, input logic [1:0] func,
			input data_t data1, input data_t data2);
		srlReq_t r;
		r.op.opClass = opClass;
		r.op.func    = func;
		r.data1      = data1;
		r.data2      = data2;
		r.issueNo    = nextIssue;
		nextIssue    = nextIssue + 1'b1;
		reqQ.push_back(r);
	endtask

	// every shift amount for each function, then a random mix.
	task automatic buildRequests();
		data_t       data2;
		logic [31:0] rnd;
		for (int a = 0; a < 32; a++) begin
			data2 = $urandom;
			data2[shamtWidth-1:0] = a[shamtWidth-1:0];
			queueReq(classShift, fnSll, $urandom, data2);
			queueReq(classShift, fnSrl, $urandom, data2);
			queueReq(classShift, fnSra, {1'b1, 31'($urandom)}, data2); // negative data1.
			queueReq(classShift, 2'd3, $urandom, data2);
			queueReq(classRotate, fnRol, $urandom, data2);
			queueReq(classRotate, fnRor, $urandom, data2);
			queueReq(classLogic, a[1:0], $urandom, $urandom);
			queueReq(classNone, a[1:0], $urandom, $urandom);
		end
		for (int i = 0; i < randomCount; i++) begin
			rnd = $urandom;
			queueReq(rnd[1:0], rnd[3:2], $urandom, $urandom);
		end
	endtask

	task automatic checkResult(input string name, input srlResult_t got,
			input srlResult_t want);
		if (got !== want) begin
			$display("FAILED t=%0t %s: got data %h issue %h, expected data %h issue %h",
				$time, name, got.data, got.issueNo, want.data, want.issueNo);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("FAILED t=%0t %s: got %b, expected %b", $time, name, got, want);
			valueErrors++;
		end
	endtask

	// one cycle. drive after the falling edge, sample just before the rising edge.
	task automatic runCycle();
		srlResult_t expected;
		@(negedge clock);
		if (taken) begin
			inValid = 1'b0;
			taken   = 1'b0;
		end
		if (!inValid && reqQ.size() > 0 && chance(70)) begin
			inReq   = reqQ.pop_front();
			inValid = 1'b1;
		end
		outReady = (readyMode == 0) ? chance(60) : (readyMode == 2);
		#4;
		if (heldPending) begin
			checkBit("outValid", outValid, 1'b1);
			checkResult("outResult", outResult, heldResult);
		end
		heldPending = outValid && !outReady;
		heldResult  = outResult;
		lastInReady = inReady;
		if (outValid && outReady) begin
			consumeCount++;
			if (expQ.size() == 0) begin
				$display("t=%0t: a result came out with no request waiting for it",
					$time);
				flowErrors++;
			end else begin
				expected = expQ.pop_front();
				checkResult("outResult", outResult, expected);
			end
		end
		if (inValid && inReady) begin
			expQ.push_back(modelResult(inReq));
			acceptCount++;
			taken = 1'b1;
		end
		@(posedge clock);
	endtask

	task automatic drainLane();
		int cycles;
		cycles = 0;
		while (reqQ.size() > 0 || expQ.size() > 0 || inValid) begin
			if (cycles == drainLimit) begin
				$display("timeout: lane did not drain, %0d results still expected",
					expQ.size());
				timeouts++;
				return;
			end
			cycles++;
			runCycle();
		end
	endtask

	// with outReady low the lane takes two requests, then stalls.
	task automatic stallCheck();
		int startCount;
		int waited;
		if (timeouts > 0) begin
			return;
		end
		for (int k = 0; k < 6; k++) begin
			queueReq(k[1:0], 2'd1, $urandom, $urandom);
		end
		readyMode  = 1;
		startCount = acceptCount;
		waited     = 0;
		runCycle();
		while (lastInReady) begin
			if (waited == stallLimit) begin
				$display("timeout: inReady stayed high with outReady held low");
				timeouts++;
				return;
			end
			waited++;
			runCycle();
		end
		if (acceptCount - startCount > 2) begin
			$display("t=%0t: %0d requests accepted under a full stall, at most 2 allowed",
				$time, acceptCount - startCount);
			flowErrors++;
		end
		readyMode = 2; // a single consume.
		runCycle();
		checkBit("inReady", lastInReady, 1'b1);
		readyMode = 0;
	endtask

	initial begin
		void'($urandom(26));
		clock        = 1'b0;
		reset        = 1'b1;
		inValid      = 1'b0;
		inReq        = '0;
		outReady     = 1'b0;
		heldPending  = 1'b0;
		heldResult   = '0;
		taken        = 1'b0;
		lastInReady  = 1'b0;
		nextIssue    = '0;
		readyMode    = 0;
		acceptCount  = 0;
		consumeCount = 0;
		valueErrors  = 0;
		flowErrors   = 0;
		timeouts     = 0;
		assertErrors = 0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		#4;
		checkBit("outValid", outValid, 1'b0);
		checkBit("inReady", inReady, 1'b1);
		buildRequests();
		drainLane();
		stallCheck();
		drainLane();
		if (expQ.size() != 0 || acceptCount != consumeCount) begin
			$display("run ended with %0d results never delivered", expQ.size());
			flowErrors++;
		end
		assertErrors = u_dut.u_chk.failCount;
		$display("errors: %0d value, %0d flow, %0d timeout, %0d assertion",
			valueErrors, flowErrors, timeouts, assertErrors);
		if (valueErrors == 0 && flowErrors == 0 && timeouts == 0 && assertErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- flist.f
verilog/srlPkg.sv
verilog/shiftRotateUnit.sv
verilog/logicUnit.sv
verilog/srlResultStage.sv
verilog/srlUnit.sv
tests/srlUnit_chk.sv
tests/srlUnitTb.sv

//--- Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP    = srlUnitTb
FLIST  = flist.f
OBJDIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJDIR)
